//--- Makefile
TOOL      := verilator
FLAGS     := --binary --timing --assert
TOP       := rv_core_tb
FILELIST  := vlog.f
BUILD_DIR := obj_dir
LOG       := sim.log
SIM_ARGS  := +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hdl/rv_core.sv
`timescale 1ns/1ps

module rv_core (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    insn_valid,
  input  rv_isa_pkg::rv_insn_t    insn,
  output logic                    insn_ready,
  output logic                    retire_valid,
  output rv_isa_pkg::rv_word_t    retire_pc,
  output rv_isa_pkg::rv_reg_idx_t retire_rd,
  output rv_isa_pkg::rv_word_t    retire_data,
  output logic                    halt
);

  rv_dec_if dec_bus ();
  rv_rf_if  rf_bus ();

  // decode is purely combinational on the offered instruction
  rv_decoder dec0 (
    .insn (insn),
    .dec  (dec_bus.decoder)
  );

  rv_regfile rf0 (
    .clk (clk),
    .rst (rst),
    .rf  (rf_bus.regfile)
  );

  rv_execute ex0 (
    .clk          (clk),
    .rst          (rst),
    .insn_valid   (insn_valid),
    .insn_ready   (insn_ready),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data),
    .halt         (halt),
    .dec          (dec_bus.execute),
    .rf           (rf_bus.execute)
  );

endmodule

//--- hdl/rv_core_pkg.sv
package rv_core_pkg;

  // operation selected by the decoder for the execute stage
  typedef enum logic [1:0] {
    alu_add,
    alu_sll,
    alu_or,
    alu_lui
  } rv_alu_op_e;

  // halted is left only through reset
  typedef enum logic {
    run,
    halted
  } rv_run_state_e;

endpackage

//--- hdl/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder (
  input  rv_isa_pkg::rv_insn_t insn,
  rv_dec_if.decoder            dec
);

  rv_isa_pkg::rv_opcode_t opcode;
  rv_isa_pkg::rv_funct3_t funct3;
  rv_isa_pkg::rv_funct7_t funct7;
  rv_isa_pkg::rv_word_t   imm_i;
  rv_isa_pkg::rv_word_t   imm_u;

  // standard RV32 field positions
  assign opcode = insn[6:0];
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];

  assign dec.rd    = insn[11:7];
  assign dec.rs1   = insn[19:15];
  assign dec.shamt = insn[24:20];

  // I immediate sign-extended from bit 31
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  // U immediate sits in the upper 20 bits
  assign imm_u = {insn[31:12], 12'b0};

  always_comb begin
    dec.alu_op  = rv_core_pkg::alu_add;
    dec.imm     = imm_i;
    dec.illegal = 1'b0;

    case (opcode)
      rv_isa_pkg::op_lui: begin
        dec.alu_op = rv_core_pkg::alu_lui;
        dec.imm    = imm_u;
      end

      rv_isa_pkg::op_reg_imm: begin
        case (funct3)
          rv_isa_pkg::f3_addi: begin
            dec.alu_op = rv_core_pkg::alu_add;
          end
          rv_isa_pkg::f3_ori: begin
            dec.alu_op = rv_core_pkg::alu_or;
          end
          rv_isa_pkg::f3_slli: begin
            dec.alu_op = rv_core_pkg::alu_sll;
            // shift encodings with upper bits set are srai-style, not supported
            dec.illegal = (funct7 != rv_isa_pkg::funct7_zero);
          end
          default: begin
            dec.illegal = 1'b1;
          end
        endcase
      end

      default: begin
        dec.illegal = 1'b1;
      end
    endcase
  end

endmodule

//--- hdl/rv_execute.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_execute (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    insn_valid,
  output logic                    insn_ready,
  output logic                    retire_valid,
  output rv_isa_pkg::rv_word_t    retire_pc,
  output rv_isa_pkg::rv_reg_idx_t retire_rd,
  output rv_isa_pkg::rv_word_t    retire_data,
  output logic                    halt,
  rv_dec_if.execute               dec,
  rv_rf_if.execute                rf
);

  rv_core_pkg::rv_run_state_e state;
  rv_isa_pkg::rv_word_t       pc;
  rv_isa_pkg::rv_word_t       alu_result;
  logic                       accept;
  logic                       commit;

  assign insn_ready = (state == rv_core_pkg::run);
  assign halt       = (state == rv_core_pkg::halted);

  assign accept = insn_valid && insn_ready;
  // only legal instructions write and retire
  assign commit = accept && !dec.illegal;

  always_comb begin
    case (dec.alu_op)
      rv_core_pkg::alu_add: alu_result = rf.rs1_data + dec.imm;
      rv_core_pkg::alu_sll: alu_result = rf.rs1_data << dec.shamt;
      rv_core_pkg::alu_or:  alu_result = rf.rs1_data | dec.imm;
      default:              alu_result = dec.imm;
    endcase
  end

  // register file steering
  assign rf.rs1     = dec.rs1;
  assign rf.rd      = dec.rd;
  assign rf.rd_data = alu_result;
  assign rf.we      = commit;

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= rv_core_pkg::run;
      pc           <= `RV_RESET_PC;
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= commit;
      if (commit) begin
        pc <= pc + `RV_PC_STEP;
      end
      // an illegal encoding stops the core until the next reset
      if (accept && dec.illegal) begin
        state <= rv_core_pkg::halted;
      end
    end
  end

  // retire payload, qualified by retire_valid
  always_ff @(posedge clk) begin
    if (commit) begin
      retire_pc   <= pc;
      retire_rd   <= dec.rd;
      retire_data <= alu_result;
    end
  end

endmodule

//--- hdl/rv_ifaces.sv
`timescale 1ns/1ps

// decoded fields of the instruction on the input stream
interface rv_dec_if;
  rv_isa_pkg::rv_reg_idx_t rd;
  rv_isa_pkg::rv_reg_idx_t rs1;
  rv_core_pkg::rv_alu_op_e alu_op;
  // sign-extended I immediate, or U immediate already shifted by 12
  rv_isa_pkg::rv_word_t    imm;
  rv_isa_pkg::rv_shamt_t   shamt;
  logic                    illegal;

  modport decoder (output rd, rs1, alu_op, imm, shamt, illegal);
  modport execute (input rd, rs1, alu_op, imm, shamt, illegal);
endinterface

// one read port and one write port of the register file
interface rv_rf_if;
  rv_isa_pkg::rv_reg_idx_t rs1;
  rv_isa_pkg::rv_word_t    rs1_data;
  rv_isa_pkg::rv_reg_idx_t rd;
  rv_isa_pkg::rv_word_t    rd_data;
  logic                    we;

  modport regfile (input rs1, rd, rd_data, we, output rs1_data);
  modport execute (output rs1, rd, rd_data, we, input rs1_data);
endinterface

//--- hdl/rv_isa_pkg.sv
`include "rv_settings.svh"

package rv_isa_pkg;

  // data and address words
  typedef logic [`RV_XLEN-1:0] rv_word_t;

  // raw instruction word, always 32 bits in RV32
  typedef logic [31:0] rv_insn_t;

  typedef logic [4:0] rv_reg_idx_t;
  typedef logic [4:0] rv_shamt_t;

  // instruction fields
  typedef logic [6:0] rv_opcode_t;
  typedef logic [2:0] rv_funct3_t;
  typedef logic [6:0] rv_funct7_t;

  // major opcodes
  localparam rv_opcode_t op_lui     = 7'b01_101_11;
  localparam rv_opcode_t op_reg_imm = 7'b00_100_11;

  // funct3 values inside op_reg_imm
  localparam rv_funct3_t f3_addi = 3'b000;
  localparam rv_funct3_t f3_slli = 3'b001;
  localparam rv_funct3_t f3_ori  = 3'b110;

  // slli needs the upper immediate bits clear
  localparam rv_funct7_t funct7_zero = 7'b000_0000;

endpackage

//--- hdl/rv_regfile.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_regfile (
  input logic       clk,
  input logic       rst,
  rv_rf_if.regfile  rf
);

  rv_isa_pkg::rv_word_t regs [`RV_REG_COUNT];

  // combinational read, so a write at this edge is seen by the next instruction
  assign rf.rs1_data = regs[rf.rs1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (rf.we && (rf.rd != '0)) begin
      // x0 never takes a write and so keeps its reset value of zero
      regs[rf.rd] <= rf.rd_data;
    end
  end

endmodule

//--- hdl/rv_settings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// datapath word width for RV32
`define RV_XLEN 32

// architectural integer registers, x0 included
`define RV_REG_COUNT 32

// first instruction address after reset
`define RV_RESET_PC 32'h0000_0000

// every retired instruction is one 32-bit word
`define RV_PC_STEP 32'd4

`endif

//--- tests/rv_clock_gen.sv
`timescale 1ns/1ps

module rv_clock_gen #(
  parameter int period_ns    = 8,
  parameter int reset_cycles = 3
) (
  input  logic reset_req,
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  // power-on reset, then one more pulse each time reset_req is seen at an edge
  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #1 rst = 1'b0;
    forever begin
      @(posedge clk);
      if (reset_req) begin
        #1 rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1 rst = 1'b0;
      end
    end
  end

endmodule

//--- tests/rv_core_props.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_core_props (
  input logic                 clk,
  input logic                 rst,
  input logic                 insn_valid,
  input logic                 insn_ready,
  input logic                 retire_valid,
  input rv_isa_pkg::rv_word_t retire_pc,
  input logic                 halt
);

  rv_isa_pkg::rv_word_t next_pc;
  logic                 accepted;
  int unsigned          n_source = 0;
  int unsigned          n_follow = 0;
  int unsigned          n_pc = 0;
  int unsigned          n_ready = 0;
  int unsigned          n_halt = 0;
  int unsigned          fail_count;

  assign accepted   = insn_valid && insn_ready;
  assign fail_count = n_source + n_follow + n_pc + n_ready + n_halt;

  // pc that the next retire has to carry
  always_ff @(posedge clk) begin
    if (rst) begin
      next_pc <= `RV_RESET_PC;
    end else if (retire_valid) begin
      next_pc <= next_pc + `RV_PC_STEP;
    end
  end

  // covers gaps in insn_valid too
  retire_has_source: assert property (@(posedge clk) disable iff (rst)
      retire_valid |-> $past(accepted))
    else begin
      n_source++;
      $error("retire without an accepted instruction one cycle before");
    end

  accept_then_retire: assert property (@(posedge clk) disable iff (rst)
      accepted |=> (retire_valid || halt))
    else begin
      n_follow++;
      $error("accepted instruction neither retired nor halted the core");
    end

  pc_steps: assert property (@(posedge clk) disable iff (rst)
      retire_valid |-> (retire_pc == next_pc))
    else begin
      n_pc++;
      $error("retire_pc %h, the next pc in sequence is %h", retire_pc, next_pc);
    end

  // once the core stops taking instructions only a reset brings ready back
  ready_stays_low: assert property (@(posedge clk) disable iff (rst)
      !insn_ready |=> !insn_ready)
    else begin
      n_ready++;
      $error("insn_ready rose again without a reset");
    end

  halt_sticks: assert property (@(posedge clk) disable iff (rst)
      halt |=> halt)
    else begin
      n_halt++;
      $error("halt dropped without a reset");
    end

endmodule

//--- tests/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;

  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam int lui_rounds = 4;
  localparam int chain_len  = 24;
  localparam int slli_count = 8;
  localparam int halt_hold  = 4;
  // two resets, two lui groups, chain, slli, x0 group, three gaps, halt, drain
  localparam int stim_cycles = 6 + 4 * lui_rounds + chain_len + slli_count + 4 + 6 + 1
                               + halt_hold + 3;
  localparam int timeout_cycles = 2 * stim_cycles + 50;

  logic        clk;
  logic        rst;
  logic        reset_req;
  logic        insn_valid;
  logic [31:0] insn;
  logic        insn_ready;
  logic        retire_valid;
  logic [31:0] retire_pc;
  logic [4:0]  retire_rd;
  logic [31:0] retire_data;
  logic        halt;

  int          seed = 32'h6d7bfc1c;
  int unsigned errors = 0;
  int unsigned retires = 0;
  int unsigned cycle_count = 0;
  logic [31:0] ref_regs [32];
  string       exp_name [$];
  logic [4:0]  exp_rd [$];
  logic [31:0] exp_data [$];

  rv_clock_gen #(.period_ns(8), .reset_cycles(3)) clk0 (
    .reset_req (reset_req),
    .clk       (clk),
    .rst       (rst)
  );

  rv_core dut0 (
    .clk          (clk),
    .rst          (rst),
    .insn_valid   (insn_valid),
    .insn         (insn),
    .insn_ready   (insn_ready),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data),
    .halt         (halt)
  );

  bind rv_core rv_core_props props0 (
    .clk          (clk),
    .rst          (rst),
    .insn_valid   (insn_valid),
    .insn_ready   (insn_ready),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .halt         (halt)
  );

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  // offer the word and hold it until the core takes it
  task automatic send_insn(input logic [31:0] word);
    insn_valid = 1'b1;
    insn       = word;
    @(negedge clk);
    while (!insn_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  // model registers change at issue, since the core writes at acceptance
  task automatic issue(input string name, input logic [31:0] word, input logic [4:0] rd,
                       input logic [31:0] value);
    exp_name.push_back(name);
    exp_rd.push_back(rd);
    exp_data.push_back(value);
    if (rd != 5'd0) begin
      ref_regs[rd] = value;
    end
    send_insn(word);
  endtask

  task automatic run_lui(input string name, input logic [4:0] rd, input logic [19:0] imm);
    issue(name, {imm, rd, opc_lui}, rd, {imm, 12'h000});
  endtask

  // funct3 6 is ori, anything else passed here is addi
  task automatic run_imm(input string name, input logic [2:0] f3, input logic [4:0] rd,
                         input logic [4:0] rs1, input logic [11:0] imm);
    logic [31:0] simm;
    logic [31:0] value;
    simm  = {{20{imm[11]}}, imm};
    value = (f3 == 3'b110) ? (ref_regs[rs1] | simm) : (ref_regs[rs1] + simm);
    issue(name, {imm, rs1, f3, rd, opc_op_imm}, rd, value);
  endtask

  task automatic run_slli(input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] sh);
    issue("slli", {7'b0, sh, rs1, 3'b001, rd, opc_op_imm}, rd, ref_regs[rs1] << sh);
  endtask

  // lui to a random register, then ori with a zero immediate reads it back
  task automatic lui_readback(input string tag);
    logic [31:0] r;
    logic [4:0]  rd;
    for (int i = 0; i < lui_rounds; i++) begin
      r  = rand_word();
      rd = (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
      run_lui(tag, rd, r[31:12]);
      run_imm({tag, " readback"}, 3'b110, r[9:5], rd, 12'h000);
    end
  endtask

  task automatic idle_cycles(input int n);
    insn_valid = 1'b0;
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic apply_reset();
    insn_valid = 1'b0;
    reset_req  = 1'b1;
    @(posedge rst);
    reset_req = 1'b0;
    @(negedge rst);
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = '0;
    end
  endtask

  task automatic check_retire();
    string       name;
    logic [4:0]  rd;
    logic [31:0] data;
    assert (exp_data.size() != 0) else begin
      errors++;
      $display("unexpected retire at pc %h with no instruction outstanding", retire_pc);
    end
    if (exp_data.size() != 0) begin
      name = exp_name.pop_front();
      rd   = exp_rd.pop_front();
      data = exp_data.pop_front();
      retires++;
      assert (retire_rd == rd) else begin
        errors++;
        $display("Mismatch %s: retire_rd expected %0d actual %0d", name, rd, retire_rd);
      end
      assert (retire_data == data) else begin
        errors++;
        $display("Mismatch %s: retire_data expected %h actual %h", name, data, retire_data);
      end
    end
  endtask

  // retire outputs are stable at the falling edge
  always @(negedge clk) begin
    if (!rst && retire_valid) begin
      check_retire();
    end
  end

  initial begin
    while (cycle_count < timeout_cycles) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: run did not finish within %0d cycles", timeout_cycles);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    logic [31:0] r;
    logic [4:0]  rs1;
    logic [4:0]  prev_rd;
    insn_valid = 1'b0;
    insn       = '0;
    reset_req  = 1'b0;
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = '0;
    end
    @(negedge rst);

    lui_readback("lui");
    idle_cycles(2);

    // back to back, about half the time reading the register just written
    prev_rd = 5'd1;
    for (int i = 0; i < chain_len; i++) begin
      r   = rand_word();
      rs1 = r[5] ? prev_rd : r[10:6];
      if (r[23]) begin
        run_imm("ori", 3'b110, r[4:0], rs1, r[22:11]);
      end else begin
        run_imm("addi", 3'b000, r[4:0], rs1, r[22:11]);
      end
      prev_rd = r[4:0];
    end
    idle_cycles(2);

    for (int i = 0; i < slli_count; i++) begin
      r = rand_word();
      run_slli(r[4:0], r[9:5], r[14:10]);
    end
    idle_cycles(2);

    run_imm("x0 write", 3'b000, 5'd0, 5'd3, 12'h123);
    r = rand_word();
    run_lui("x0 lui", 5'd0, r[19:0]);
    run_imm("x0 read", 3'b110, 5'd9, 5'd0, 12'h000);
    run_imm("x0 read", 3'b000, 5'd10, 5'd0, 12'hfff);

    // a load is outside the supported set
    send_insn({12'h000, 5'd1, 3'b010, 5'd2, opc_load});
    assert (halt && !insn_ready) else begin
      errors++;
      $display("halt did not rise one cycle after the illegal instruction");
    end
    insn = {20'h12345, 5'd4, opc_lui};
    repeat (halt_hold) @(posedge clk);
    #1;
    apply_reset();
    lui_readback("lui after reset");
    idle_cycles(3);

    assert (exp_data.size() == 0) else begin
      errors++;
      $display("%0d expected retires never appeared", exp_data.size());
    end
    $display("retires checked %0d, testbench errors %0d, assertion failures %0d",
             retires, errors, dut0.props0.fail_count);
    if (errors == 0 && dut0.props0.fail_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+hdl
hdl/rv_isa_pkg.sv
hdl/rv_core_pkg.sv
hdl/rv_ifaces.sv
hdl/rv_decoder.sv
hdl/rv_regfile.sv
hdl/rv_execute.sv
hdl/rv_core.sv
tests/rv_clock_gen.sv
tests/rv_core_props.sv
tests/rv_core_tb.sv
